// ==== common/masku_if.sv ====
`timescale 1ns/100ps

`include "masku_params.svh"

// Per-beat context from the instruction control to the merge stage
interface beat_if;

  // Instruction in issue phase
  logic               active;
  // High when the instruction is unmasked
  logic               vm;
  // Body bits not yet issued
  masku_pkg::vl_t     remaining;
  // Destination word address of the current beat
  masku_pkg::vaddr_t  addr;
  masku_pkg::vid_t    id;
  // One beat consumed in this cycle
  logic               fire;

  modport ctrl (
    output active, vm, remaining, addr, id,
    input  fire
  );

  modport merge (
    input  active, vm, remaining, addr, id,
    output fire
  );

endinterface

// Merged words on their way to the result queue
interface result_if;

  logic               valid;
  logic               ready;
  masku_pkg::word_t   data;
  masku_pkg::vaddr_t  addr;
  masku_pkg::vid_t    id;

  modport src (output valid, data, addr, id, input ready);

  modport dst (input valid, data, addr, id, output ready);

endinterface

// ==== common/masku_params.svh ====
`ifndef MASKU_PARAMS_SVH
`define MASKU_PARAMS_SVH

////////////////////
// Datapath widths
////////////////////

// Bits per operand beat and per written mask word
`define MASKU_WORD_W 64

// Vector length, wide enough to hold vl = 1024
`define MASKU_VL_W 11

// Register file word address
`define MASKU_ADDR_W 8

// Instruction id from the sequencer
`define MASKU_ID_W 3

// Merged words waiting for the register file
`define MASKU_RQ_DEPTH 2

`endif

// ==== common/masku_pkg.sv ====
package masku_pkg;

  `include "masku_params.svh"

  ////////////////////
  // Width types
  ////////////////////

  // One mask word, one bit per element
  typedef logic [`MASKU_WORD_W-1:0] word_t;

  // Vector length, also used for remaining body bits and word counts
  typedef logic [`MASKU_VL_W-1:0] vl_t;

  // Word address inside the vector register file
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;

  // Sequencer instruction id
  typedef logic [`MASKU_ID_W-1:0] vid_t;

  ////////////////////
  // Control FSM
  ////////////////////

  // IDLE waits for a request, ISSUE consumes beats,
  // COMMIT waits for the last register file write
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    COMMIT
  } ctrl_state_e;

endpackage

// ==== masku/masku_insn_ctrl.sv ====
`timescale 1ns/100ps

`include "masku_params.svh"

module masku_insn_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  masku_pkg::vid_t    req_id_i,
  input  masku_pkg::vl_t     req_vl_i,
  input  masku_pkg::vaddr_t  req_vd_i,
  input  logic               req_vm_i,
  beat_if.ctrl               beat,
  input  logic               wr_fire_i,
  output logic               done_o,
  output masku_pkg::vid_t    done_id_o
);

  masku_pkg::ctrl_state_e state_d, state_q;
  // Body bits still to issue, words still to write
  masku_pkg::vl_t         remaining_q;
  masku_pkg::vl_t         commit_cnt_q;
  masku_pkg::vl_t         req_words;
  masku_pkg::vaddr_t      addr_q;
  masku_pkg::vid_t        id_q;
  logic                   vm_q;
  logic                   accept;
  logic                   last_beat;
  logic                   last_write;

  // Only one instruction in flight
  assign req_ready_o = (state_q == masku_pkg::IDLE);
  assign accept      = req_valid_i & req_ready_o;

  // Final beat once at most one word of body bits is left
  assign last_beat  = beat.fire &
                      (remaining_q <= masku_pkg::vl_t'(`MASKU_WORD_W));
  assign last_write = wr_fire_i & (commit_cnt_q == masku_pkg::vl_t'(1));

  // Words per instruction, vl rounded up; vl of zero still writes one word
  always_comb begin
    req_words = (req_vl_i + masku_pkg::vl_t'(`MASKU_WORD_W - 1)) >> $clog2(`MASKU_WORD_W);
    if (req_vl_i == '0) begin
      req_words = masku_pkg::vl_t'(1);
    end
  end

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      masku_pkg::IDLE:   if (accept)     state_d = masku_pkg::ISSUE;
      masku_pkg::ISSUE:  if (last_beat)  state_d = masku_pkg::COMMIT;
      masku_pkg::COMMIT: if (last_write) state_d = masku_pkg::IDLE;
      default:                           state_d = masku_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= masku_pkg::IDLE;
      remaining_q  <= '0;
      commit_cnt_q <= '0;
      done_o       <= 1'b0;
    end else begin
      state_q <= state_d;
      // Pulse in the cycle after the last write
      done_o  <= last_write;
      if (accept) begin
        remaining_q  <= req_vl_i;
        commit_cnt_q <= req_words;
      end else begin
        // Saturating step of one word per consumed beat
        if (beat.fire) begin
          if (remaining_q > masku_pkg::vl_t'(`MASKU_WORD_W)) begin
            remaining_q <= remaining_q - masku_pkg::vl_t'(`MASKU_WORD_W);
          end else begin
            remaining_q <= '0;
          end
        end
        if (wr_fire_i) begin
          commit_cnt_q <= commit_cnt_q - masku_pkg::vl_t'(1);
        end
      end
    end
  end

  // Instruction fields, next address steps with every beat
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q   <= req_id_i;
      vm_q   <= req_vm_i;
      addr_q <= req_vd_i;
    end else if (beat.fire) begin
      addr_q <= addr_q + masku_pkg::vaddr_t'(1);
    end
  end

  assign beat.active    = (state_q == masku_pkg::ISSUE);
  assign beat.vm        = vm_q;
  assign beat.remaining = remaining_q;
  assign beat.addr      = addr_q;
  assign beat.id        = id_q;

  // Id stays stable until the next request is taken
  assign done_id_o = id_q;

endmodule

// ==== masku/masku_merge.sv ====
`timescale 1ns/100ps

`include "masku_params.svh"

module masku_merge (
  // New result bits
  input  masku_pkg::word_t opa_data_i,
  input  logic             opa_valid_i,
  output logic             opa_ready_o,
  // Old destination word
  input  masku_pkg::word_t opb_data_i,
  input  logic             opb_valid_i,
  output logic             opb_ready_o,
  // Mask word
  input  masku_pkg::word_t opm_data_i,
  input  logic             opm_valid_i,
  output logic             opm_ready_o,
  beat_if.merge            beat,
  result_if.src            res
);

  // Tail length inside a partial word
  logic [$clog2(`MASKU_WORD_W)-1:0] tail_len;
  masku_pkg::word_t                 body_en;
  masku_pkg::word_t                 bit_en;
  logic                             operands_valid;

  ////////////////////
  // Bit enable
  ////////////////////

  assign tail_len = beat.remaining[$clog2(`MASKU_WORD_W)-1:0];

  // Whole word in the body, or only the bits below the remaining count
  always_comb begin
    if (beat.remaining >= masku_pkg::vl_t'(`MASKU_WORD_W)) begin
      body_en = '1;
    end else begin
      body_en = ~({`MASKU_WORD_W{1'b1}} << tail_len);
    end
  end

  // Masked instructions also need the mask bit set
  assign bit_en = beat.vm ? body_en : (body_en & opm_data_i);

  // Enabled bits from a, all others keep the old value
  assign res.data = (opa_data_i & bit_en) | (opb_data_i & ~bit_en);
  assign res.addr = beat.addr;
  assign res.id   = beat.id;

  ////////////////////
  // Operand join
  ////////////////////

  // Mask channel only matters for masked instructions
  assign operands_valid = opa_valid_i & opb_valid_i & (opm_valid_i | beat.vm);

  // Valid does not look at ready, so it holds under back-pressure
  assign res.valid = beat.active & operands_valid;
  assign beat.fire = res.valid & res.ready;

  // Operands are popped together with the queue push
  assign opa_ready_o = beat.fire;
  assign opb_ready_o = beat.fire;
  assign opm_ready_o = beat.fire & ~beat.vm;

endmodule

// ==== masku/masku_top.sv ====
`timescale 1ns/100ps

module masku_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer request
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  masku_pkg::vid_t    req_id_i,
  input  masku_pkg::vl_t     req_vl_i,
  input  masku_pkg::vaddr_t  req_vd_i,
  input  logic               req_vm_i,
  // New result bits from the lanes
  input  masku_pkg::word_t   opa_data_i,
  input  logic               opa_valid_i,
  output logic               opa_ready_o,
  // Old destination value
  input  masku_pkg::word_t   opb_data_i,
  input  logic               opb_valid_i,
  output logic               opb_ready_o,
  // Mask register
  input  masku_pkg::word_t   opm_data_i,
  input  logic               opm_valid_i,
  output logic               opm_ready_o,
  // Register file write
  output logic               wr_valid_o,
  input  logic               wr_ready_i,
  output masku_pkg::vaddr_t  wr_addr_o,
  output masku_pkg::word_t   wr_data_o,
  output masku_pkg::vid_t    wr_id_o,
  // Completion
  output logic               done_o,
  output masku_pkg::vid_t    done_id_o
);

  beat_if   beat ();
  result_if res ();

  // Register file handshake, counted by the commit side
  logic wr_fire;
  assign wr_fire = wr_valid_o & wr_ready_i;

  ////////////////////
  // Instruction control
  ////////////////////

  masku_insn_ctrl u_insn_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_id_i    (req_id_i),
    .req_vl_i    (req_vl_i),
    .req_vd_i    (req_vd_i),
    .req_vm_i    (req_vm_i),
    .beat        (beat.ctrl),
    .wr_fire_i   (wr_fire),
    .done_o      (done_o),
    .done_id_o   (done_id_o)
  );

  ////////////////////
  // Merge
  ////////////////////

  masku_merge u_merge (
    .opa_data_i  (opa_data_i),
    .opa_valid_i (opa_valid_i),
    .opa_ready_o (opa_ready_o),
    .opb_data_i  (opb_data_i),
    .opb_valid_i (opb_valid_i),
    .opb_ready_o (opb_ready_o),
    .opm_data_i  (opm_data_i),
    .opm_valid_i (opm_valid_i),
    .opm_ready_o (opm_ready_o),
    .beat        (beat.merge),
    .res         (res.src)
  );

  ////////////////////
  // Result queue
  ////////////////////

  result_queue u_result_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .res        (res.dst),
    .wr_valid_o (wr_valid_o),
    .wr_ready_i (wr_ready_i),
    .wr_addr_o  (wr_addr_o),
    .wr_data_o  (wr_data_o),
    .wr_id_o    (wr_id_o)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module masku_tb -f sim.f -o masku_sim &&
./obj_dir/masku_sim | tee /dev/stderr | grep "Everything OK" > /dev/null &&
echo "run.sh: simulation passed" || { echo "run.sh: simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+common
common/masku_pkg.sv
common/masku_if.sv
src/result_queue.sv
masku/masku_merge.sv
masku/masku_insn_ctrl.sv
masku/masku_top.sv
testbench/masku_checker.sv
testbench/masku_tb.sv

// ==== src/result_queue.sv ====
`timescale 1ns/100ps

`include "masku_params.svh"

module result_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  result_if.dst             res,
  output logic              wr_valid_o,
  input  logic              wr_ready_i,
  output masku_pkg::vaddr_t wr_addr_o,
  output masku_pkg::word_t  wr_data_o,
  output masku_pkg::vid_t   wr_id_o
);

  localparam int unsigned ptr_w = (`MASKU_RQ_DEPTH > 1) ? $clog2(`MASKU_RQ_DEPTH) : 1;
  localparam int unsigned cnt_w = $clog2(`MASKU_RQ_DEPTH + 1);

  // Entry storage
  masku_pkg::word_t  data_mem [`MASKU_RQ_DEPTH];
  masku_pkg::vaddr_t addr_mem [`MASKU_RQ_DEPTH];
  masku_pkg::vid_t   id_mem   [`MASKU_RQ_DEPTH];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             push;
  logic             pop;

  // Back-pressure towards the merge stage when full
  assign res.ready = (cnt_q != cnt_w'(`MASKU_RQ_DEPTH));
  assign push      = res.valid & res.ready;
  assign pop       = wr_valid_o & wr_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q] <= res.data;
      addr_mem[wr_ptr_q] <= res.addr;
      id_mem[wr_ptr_q]   <= res.id;
    end
  end

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(`MASKU_RQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(`MASKU_RQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop in the same cycle leave the count unchanged
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Head entry goes out, valid one cycle after its push
  assign wr_valid_o = (cnt_q != '0);
  assign wr_data_o  = data_mem[rd_ptr_q];
  assign wr_addr_o  = addr_mem[rd_ptr_q];
  assign wr_id_o    = id_mem[rd_ptr_q];

endmodule

// ==== testbench/masku_checker.sv ====
`timescale 1ns/100ps

module masku_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic req_ready_i,
  input logic opa_valid_i,
  input logic opa_ready_i,
  input logic opb_valid_i,
  input logic opb_ready_i,
  input logic opm_valid_i,
  input logic opm_ready_i,
  input logic wr_valid_i,
  input logic wr_ready_i,
  input logic done_i
);

  // Assertion failures so far
  int fail_cnt = 0;

  ////////////////////
  // Register file side
  ////////////////////

  // A pending write stays up until the register file takes it
  wr_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid_i && !wr_ready_i |=> wr_valid_i)
    else begin
      $error("wr_valid_o dropped before wr_ready_i");
      fail_cnt++;
    end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else begin
      $error("done_o high for more than one cycle");
      fail_cnt++;
    end

  // No new instruction while words of the current one are still queued
  req_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid_i |-> !req_ready_i)
    else begin
      $error("req_ready_o high while wr_valid_o is high");
      fail_cnt++;
    end

  ////////////////////
  // Operand channels
  ////////////////////

  op_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!opa_ready_i || opa_valid_i) && (!opb_ready_i || opb_valid_i) &&
    (!opm_ready_i || opm_valid_i))
    else begin
      $error("operand ready raised without its valid");
      fail_cnt++;
    end

endmodule

bind masku_top masku_checker u_checker (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_ready_i (req_ready_o),
  .opa_valid_i (opa_valid_i),
  .opa_ready_i (opa_ready_o),
  .opb_valid_i (opb_valid_i),
  .opb_ready_i (opb_ready_o),
  .opm_valid_i (opm_valid_i),
  .opm_ready_i (opm_ready_o),
  .wr_valid_i  (wr_valid_o),
  .wr_ready_i  (wr_ready_i),
  .done_i      (done_o)
);

// ==== testbench/masku_tb.sv ====
`timescale 1ns/100ps

module masku_tb;

  localparam int clk_period  = 20;
  localparam int word_w      = 64;
  // Watchdog budget from the words over all tests times a margin plus reset
  localparam int total_words = 12;
  localparam int wd_cycles   = 8 + total_words * 40;

  logic              clk_i, rst_ni;
  logic              req_valid_i, req_ready_o, req_vm_i;
  masku_pkg::vid_t   req_id_i, wr_id_o, done_id_o;
  masku_pkg::vl_t    req_vl_i;
  masku_pkg::vaddr_t req_vd_i, wr_addr_o;
  masku_pkg::word_t  opa_data_i, opb_data_i, opm_data_i, wr_data_o;
  logic              opa_valid_i, opb_valid_i, opm_valid_i;
  logic              opa_ready_o, opb_ready_o, opm_ready_o;
  logic              wr_valid_o, wr_ready_i, done_o;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lfsr_q;

  masku_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per data bit
  function automatic masku_pkg::word_t random_word();
    masku_pkg::word_t w;
    for (int i = 0; i < word_w; i++) begin
      w[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
    return w;
  endfunction

  // Bit from a inside the body with its mask bit set, from b everywhere else
  function automatic masku_pkg::word_t expected_word(input masku_pkg::word_t a, b, m,
                                                     input int word_idx, vl, input logic vm);
    masku_pkg::word_t w;
    for (int i = 0; i < word_w; i++) begin
      w[i] = ((word_idx * word_w + i < vl) && (vm || m[i])) ? a[i] : b[i];
    end
    return w;
  endfunction

  task automatic compare_hex(input string sig, input logic [63:0] got, exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    errors++;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s, %0d errors", name, errors - errors_before);
    end
  endtask

  // Holds the request up until the DUT takes it
  task automatic send_req(input masku_pkg::vid_t id, input int vl, input masku_pkg::vaddr_t vd,
                          input logic vm, output int wait_cycles);
    logic accepted;
    accepted    = 1'b0;
    wait_cycles = 0;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_id_i    = id;
    req_vl_i    = masku_pkg::vl_t'(vl);
    req_vd_i    = vd;
    req_vm_i    = vm;
    while (!accepted) begin
      #1;
      if (req_ready_o) begin
        accepted = 1'b1;
      end else begin
        wait_cycles++;
        @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Serves the operand channels and checks every write up to the done pulse
  task automatic serve_insn(input masku_pkg::vid_t id, input int vl, input masku_pkg::vaddr_t vd,
                            input logic vm, input int stall_from, input int stall_len);
    masku_pkg::word_t opa[$];
    masku_pkg::word_t opb[$];
    masku_pkg::word_t opm[$];
    masku_pkg::word_t exp_data[$];
    int               n_words;
    int               beat_idx;
    int               wr_idx;
    int               cycle;
    logic             fire;
    logic             finished;
    n_words = (vl == 0) ? 1 : (vl + word_w - 1) / word_w;
    for (int w = 0; w < n_words; w++) begin
      opa.push_back(random_word());
      opb.push_back(random_word());
      opm.push_back(random_word());
      exp_data.push_back(expected_word(opa[w], opb[w], opm[w], w, vl, vm));
    end
    beat_idx = 0;
    wr_idx   = 0;
    cycle    = 0;
    fire     = 1'b0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk_i);
      // Outcome of the last rising edge
      if (fire) begin
        beat_idx++;
      end
      if (done_o) begin
        finished = 1'b1;
        if (wr_idx != n_words) begin
          report_error($sformatf("done came after %0d of %0d writes", wr_idx, n_words));
        end
        compare_hex("done_id_o", done_id_o, id);
      end
      // Register file stall window
      wr_ready_i  = !(cycle >= stall_from && cycle < stall_from + stall_len);
      opa_valid_i = (beat_idx < n_words);
      opb_valid_i = (beat_idx < n_words);
      opm_valid_i = (beat_idx < n_words) && !vm;
      if (beat_idx < n_words) begin
        opa_data_i = opa[beat_idx];
        opb_data_i = opb[beat_idx];
        opm_data_i = opm[beat_idx];
      end
      #1;
      fire = opa_ready_o;
      if (opb_ready_o !== fire || opm_ready_o !== (fire && !vm)) begin
        report_error("operand readies do not move together");
      end
      if (wr_valid_o && wr_ready_i) begin
        if (wr_idx >= n_words) begin
          report_error("register file write beyond the last word");
        end else begin
          compare_hex("wr_data_o", wr_data_o, exp_data[wr_idx]);
          compare_hex("wr_addr_o", wr_addr_o, vd + masku_pkg::vaddr_t'(wr_idx));
          compare_hex("wr_id_o", wr_id_o, id);
        end
        wr_idx++;
      end
      cycle++;
    end
    wr_ready_i = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic run_single(input string name, input masku_pkg::vid_t id, input int vl,
                            input masku_pkg::vaddr_t vd, input logic vm, input int stall_from,
                            input int stall_len);
    int e0;
    int waited;
    e0 = errors;
    fork
      send_req(id, vl, vd, vm, waited);
      serve_insn(id, vl, vd, vm, stall_from, stall_len);
    join
    if (waited != 0) begin
      report_error("request was held off although the unit was idle");
    end
    report_test(name, e0);
  endtask

  // Second request is raised while the first instruction still runs
  task automatic test_back_to_back();
    int e0;
    int waited_a;
    int waited_b;
    e0 = errors;
    fork
      serve_insn(5, 128, 8'h50, 1'b0, 0, 0);
      begin
        send_req(5, 128, 8'h50, 1'b0, waited_a);
        send_req(6, 65, 8'h60, 1'b1, waited_b);
      end
    join
    if (waited_a != 0) begin
      report_error("first request was held off although the unit was idle");
    end
    if (waited_b == 0) begin
      report_error("second request was taken while the first was running");
    end
    serve_insn(6, 65, 8'h60, 1'b1, 0, 0);
    report_test("back-to-back ids 5 and 6", e0);
  endtask

  initial begin
    #(wd_cycles * clk_period);
    $display("ERROR: timeout, the tests did not finish within %0d cycles", wd_cycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    lfsr_q       = 32'd67570;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_id_i     = '0;
    req_vl_i     = '0;
    req_vd_i     = '0;
    req_vm_i     = 1'b1;
    opa_data_i   = '0;
    opb_data_i   = '0;
    opm_data_i   = '0;
    opa_valid_i  = 1'b0;
    opb_valid_i  = 1'b0;
    opm_valid_i  = 1'b0;
    wr_ready_i   = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    run_single("unmasked vl 128", 1, 128, 8'h10, 1'b1, 0, 0);
    run_single("unmasked vl 100 with partial tail", 2, 100, 8'h20, 1'b1, 0, 0);
    run_single("masked vl 64", 3, 64, 8'h30, 1'b0, 0, 0);
    // Stall starts while beats are still pending so the full queue holds the merge
    run_single("write back-pressure", 4, 192, 8'h40, 1'b1, 2, 8);
    test_back_to_back();
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, DUT.u_checker.fail_cnt);
    if (errors == 0 && DUT.u_checker.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
